// ==== all.f ====
verilog/st7789_pkg.sv
verilog/lcd_wr_if.sv
verilog/lcd_rd_if.sv
verilog/glyph_gen.sv
verilog/st7789_seq.sv
verilog/lcd_fifo.sv
verilog/axis_out_stage.sv
verilog/st7789_clock_top.sv
verification/st7789_checker.sv
verification/tb_st7789.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_st7789 -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation not ok"; exit 1; }

// ==== verification/tb_st7789.sv ====
`timescale 1ns/1ps

module tb_st7789 import st7789_pkg::*; ();

    localparam int NROWS          = 4;
    localparam int TIMEOUT_CYCLES = (NROWS + 1) * 1798 * 4 + 2000;
    localparam int BUSY_AT        = 900;  // beats into a frame
    localparam int FRAME_LEN      = NUM_DIGITS * (11 + 3 * GLYPH_W * GLYPH_H);

    logic        CLK = 1'b0;
    logic        RESET;
    logic        time_valid;
    bcd_t        hour_h, hour_l, min_h, min_l, sec_h, sec_l;
    color_t      fg_r, fg_g, fg_b, bg_r, bg_g, bg_b;
    logic        m_axis_tready;
    byte_t       m_axis_tdata;
    logic        m_axis_tuser, m_axis_tlast, m_axis_tvalid;
    logic [72:0] stim [NROWS];  // random tready, fg rgb, bg rgb, six digits
    logic        rand_mode;
    logic [15:0] lfsr;
    int          beats, frames_done, errors, fails, start;

    st7789_clock_top dut (.*);

    st7789_checker #(.NROWS(NROWS)) chk (.*);

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    always #5 CLK = ~CLK;

    always @(negedge CLK) begin
        if (rand_mode) begin
            lfsr          = lfsr_step(lfsr);
            m_axis_tready = lfsr[0];
        end else begin
            m_axis_tready = 1'b1;
        end
    end

    task automatic apply_row(int r);
        @(posedge CLK);
        rand_mode = stim[r][72];
        @(negedge CLK);
        {hour_h, hour_l, min_h, min_l, sec_h, sec_l} = stim[r][23:0];
        {fg_r, fg_g, fg_b} = stim[r][71:48];
        {bg_r, bg_g, bg_b} = stim[r][47:24];
        time_valid = 1'b1;
        @(negedge CLK);
        time_valid = 1'b0;
    endtask

    // mid-frame pulse with other digits, must change nothing
    task automatic pulse_busy();
        @(negedge CLK);
        {hour_h, hour_l, min_h, min_l, sec_h, sec_l} = 24'h888888;
        time_valid = 1'b1;
        @(negedge CLK);
        time_valid = 1'b0;
    endtask

    initial begin
        stim[0] = {1'b0, 24'hFFC020, 24'h000010, 24'h123456};
        stim[1] = {1'b1, 24'h00FF00, 24'h200000, 24'h095907};
        stim[2] = {1'b1, 24'hFFFFFF, 24'h000000, 24'hAB0FC9};  // non-bcd digits
        stim[3] = {1'b0, 24'h3080F0, 24'h101010, 24'h230841};
        RESET         = 1'b1;
        time_valid    = 1'b0;
        {hour_h, hour_l, min_h, min_l, sec_h, sec_l} = '0;
        {fg_r, fg_g, fg_b, bg_r, bg_g, bg_b} = '0;
        m_axis_tready = 1'b1;
        rand_mode     = 1'b0;
        lfsr          = 16'd28116;
        fails         = 0;
        repeat (5) @(negedge CLK);
        RESET = 1'b0;
        while (beats < 4)
            @(negedge CLK);
        repeat (60) @(negedge CLK);  // init done, panel stays quiet
        for (int r = 0; r < NROWS; r++) begin
            start = beats;
            apply_row(r);
            while (beats < start + BUSY_AT)
                @(negedge CLK);
            pulse_busy();
            while (frames_done < r + 1)
                @(negedge CLK);
        end
        repeat (100) @(negedge CLK);
        if (beats != 4 + NROWS * FRAME_LEN) begin
            $display("saw %0d beats, expected %0d for %0d table rows",
                     beats, 4 + NROWS * FRAME_LEN, NROWS);
            fails++;
        end
        $display("beats %0d, errors %0d", beats, errors + fails);
        if (errors + fails == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("timeout, frames not complete after %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== verification/st7789_checker.sv ====
`timescale 1ns/1ps

module st7789_checker import st7789_pkg::*; #(
    parameter int NROWS = 4
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        time_valid,
    input  logic [72:0] stim [NROWS],
    input  byte_t       m_axis_tdata,
    input  logic        m_axis_tuser,
    input  logic        m_axis_tlast,
    input  logic        m_axis_tvalid,
    input  logic        m_axis_tready,
    output int          beats,
    output int          frames_done,
    output int          errors
);

    localparam int FRAME_LEN = NUM_DIGITS * (11 + 3 * GLYPH_W * GLYPH_H);

    logic [9:0] expq [$];  // last, user, data
    logic       started;
    logic       stalled;
    byte_t      held;
    int         cycles;

    // seven-segment cell, 8 columns by 12 rows, strokes two pixels wide
    function automatic logic pixel_lit(logic [3:0] digit, int r, int c);
        int v;
        v = (digit > 4'd9) ? 0 : int'(digit);
        return (r < 2 && v inside {0, 2, 3, 5, 6, 7, 8, 9})            // a
            || (c >= 6 && r <= 6 && v inside {0, 1, 2, 3, 4, 7, 8, 9}) // b
            || (c >= 6 && r >= 5 && v inside {0, 1, 3, 4, 5, 6, 7, 8, 9})
            || (r >= 10 && v inside {0, 2, 3, 5, 6, 8, 9})             // d
            || (c < 2 && r >= 5 && v inside {0, 2, 6, 8})              // e
            || (c < 2 && r <= 6 && v inside {0, 4, 5, 6, 8, 9})        // f
            || (r >= 5 && r <= 6 && v inside {2, 3, 4, 5, 6, 8, 9});   // g
    endfunction

    task automatic push(byte_t data, logic user, logic last);
        expq.push_back({last, user, data});
    endtask

    task automatic push_window(byte_t cmd, int lo, int hi);
        push(cmd, 1'b0, 1'b0);
        push(byte_t'(lo >> 8), 1'b1, 1'b0);
        push(byte_t'(lo), 1'b1, 1'b0);
        push(byte_t'(hi >> 8), 1'b1, 1'b0);
        push(byte_t'(hi), 1'b1, 1'b1);
    endtask

    task automatic build_stream();
        logic [3:0]  digit;
        logic [23:0] color;
        logic        last;
        int          x;
        push(CMD_SWRESET, 1'b0, 1'b1);
        push(CMD_SLPOUT, 1'b0, 1'b1);
        push(CMD_INVON, 1'b0, 1'b1);
        push(CMD_DISPON, 1'b0, 1'b1);
        for (int k = 0; k < NROWS; k++) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                digit = stim[k][23 - 4 * i -: 4];  // hours first
                x     = ORIGIN_X + i * (GLYPH_W + GLYPH_GAP);
                push_window(CMD_CASET, x, x + GLYPH_W - 1);
                push_window(CMD_RASET, ORIGIN_Y, ORIGIN_Y + GLYPH_H - 1);
                push(CMD_RAMWR, 1'b0, 1'b0);
                for (int r = 0; r < GLYPH_H; r++) begin
                    for (int c = 0; c < GLYPH_W; c++) begin
                        color = pixel_lit(digit, r, c) ? stim[k][71:48] : stim[k][47:24];
                        last  = (r == GLYPH_H - 1) && (c == GLYPH_W - 1);
                        push(color[23:16], 1'b1, 1'b0);
                        push(color[15:8], 1'b1, 1'b0);
                        push(color[7:0], 1'b1, last);
                    end
                end
            end
        end
    endtask

    task automatic check_field(string name, int expected, int actual);
        if (expected != actual) begin
            $display("ERROR %0t %s: expected %0h, actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    initial begin
        @(negedge RESET);
        build_stream();
    end

    always @(posedge CLK) begin
        logic [9:0] exp_beat;
        if (RESET) begin
            beats       = 0;
            frames_done = 0;
            errors      = 0;
            cycles      = 0;
            started     = 1'b0;
            stalled     = 1'b0;
        end else begin
            if (stalled) begin  // beat held over from a stall
                check_field("m_axis_tvalid", 1, int'(m_axis_tvalid));
                check_field("m_axis_tdata", int'(held), int'(m_axis_tdata));
            end
            if (m_axis_tvalid && m_axis_tready) begin
                if (cycles < 4) begin
                    $display("a beat was accepted only %0d cycles after reset", cycles);
                    errors++;
                end
                if (beats >= expq.size()) begin
                    $display("a beat arrived at %0t after the expected stream ended", $time);
                    errors++;
                end else begin
                    if (beats >= 4 && !started) begin
                        $display("a beat arrived after init before any time_valid");
                        errors++;
                    end
                    exp_beat = expq[beats];
                    check_field("m_axis_tdata", int'(exp_beat[7:0]), int'(m_axis_tdata));
                    check_field("m_axis_tuser", int'(exp_beat[8]), int'(m_axis_tuser));
                    check_field("m_axis_tlast", int'(exp_beat[9]), int'(m_axis_tlast));
                end
                beats++;
                if (beats > 4 && (beats - 4) % FRAME_LEN == 0)
                    frames_done = (beats - 4) / FRAME_LEN;
            end
            if (time_valid)
                started = 1'b1;
            stalled = m_axis_tvalid && !m_axis_tready;
            held    = m_axis_tdata;
            cycles++;
        end
    end

endmodule

// ==== verilog/st7789_clock_top.sv ====
`timescale 1ns/1ps

module st7789_clock_top import st7789_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   time_valid,
    input  bcd_t   hour_h,
    input  bcd_t   hour_l,
    input  bcd_t   min_h,
    input  bcd_t   min_l,
    input  bcd_t   sec_h,
    input  bcd_t   sec_l,
    input  color_t fg_r,
    input  color_t fg_g,
    input  color_t fg_b,
    input  color_t bg_r,
    input  color_t bg_g,
    input  color_t bg_b,
    input  logic   m_axis_tready,
    output byte_t  m_axis_tdata,
    output logic   m_axis_tuser,
    output logic   m_axis_tlast,
    output logic   m_axis_tvalid
);

    lcd_wr_if wr_bus ();
    lcd_rd_if rd_bus ();

    st7789_seq u_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .time_valid (time_valid),
        .hour_h     (hour_h),
        .hour_l     (hour_l),
        .min_h      (min_h),
        .min_l      (min_l),
        .sec_h      (sec_h),
        .sec_l      (sec_l),
        .fg_r       (fg_r),
        .fg_g       (fg_g),
        .fg_b       (fg_b),
        .bg_r       (bg_r),
        .bg_g       (bg_g),
        .bg_b       (bg_b),
        .wr         (wr_bus.producer)
    );

    lcd_fifo u_fifo (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr_bus.fifo),
        .rd    (rd_bus.fifo)
    );

    axis_out_stage u_out (
        .CLK           (CLK),
        .RESET         (RESET),
        .rd            (rd_bus.consumer),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

endmodule

// ==== verilog/axis_out_stage.sv ====
`timescale 1ns/1ps

module axis_out_stage import st7789_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    lcd_rd_if.consumer rd,
    output byte_t      m_axis_tdata,
    output logic       m_axis_tuser,
    output logic       m_axis_tlast,
    output logic       m_axis_tvalid,
    input  logic       m_axis_tready
);

    // register free or its beat leaves this cycle
    assign rd.rden = (!m_axis_tvalid || m_axis_tready) && !rd.empty;

    always_ff @(posedge CLK) begin
        if (RESET)
            m_axis_tvalid <= 1'b0;
        else if (rd.rden)
            m_axis_tvalid <= 1'b1;
        else if (m_axis_tready)
            m_axis_tvalid <= 1'b0;  // taken, nothing queued
    end

    always_ff @(posedge CLK) begin
        if (rd.rden) begin
            m_axis_tdata <= rd.data;
            m_axis_tuser <= rd.user;
            m_axis_tlast <= rd.last;
        end
    end

    a_hold_beat: assert property (@(posedge CLK) disable iff (RESET)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
        else $error("tdata changed while stalled");

endmodule

// ==== verilog/lcd_fifo.sv ====
`timescale 1ns/1ps

module lcd_fifo import st7789_pkg::*; (
    input  logic    CLK,
    input  logic    RESET,
    lcd_wr_if.fifo  wr,
    lcd_rd_if.fifo  rd
);

    logic [FIFO_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr, rd_ptr;
    logic [FIFO_AW:0]   count;

    always_ff @(posedge CLK) begin
        if (wr.wren)
            mem[wr_ptr] <= {wr.last, wr.user, wr.data};
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            wr.awfull <= 1'b0;
        end else begin
            if (wr.wren)
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (rd.rden)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr.wren, rd.rden})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            wr.awfull <= (count >= FIFO_AWFULL);
        end
    end

    // show-ahead head entry
    assign {rd.last, rd.user, rd.data} = mem[rd_ptr];
    assign rd.empty = (count == '0);

    a_no_overflow: assert property (@(posedge CLK) disable iff (RESET)
        !(wr.wren && count == (FIFO_AW+1)'(FIFO_DEPTH)))
        else $error("fifo write while full");

    a_no_underflow: assert property (@(posedge CLK) disable iff (RESET)
        !(rd.rden && rd.empty))
        else $error("fifo read while empty");

endmodule

// ==== verilog/st7789_seq.sv ====
`timescale 1ns/1ps

module st7789_seq import st7789_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       time_valid,
    input  bcd_t       hour_h,
    input  bcd_t       hour_l,
    input  bcd_t       min_h,
    input  bcd_t       min_l,
    input  bcd_t       sec_h,
    input  bcd_t       sec_l,
    input  color_t     fg_r,
    input  color_t     fg_g,
    input  color_t     fg_b,
    input  color_t     bg_r,
    input  color_t     bg_g,
    input  color_t     bg_b,
    lcd_wr_if.producer wr
);

    typedef enum logic [3:0] {
        S_RESET, S_SWRESET, S_PAUSE, S_SLPOUT, S_INVON, S_DISPON,
        S_IDLE, S_CASET, S_RASET, S_RAMWR, S_PIXEL
    } state_t;

    state_t             state;
    logic [PAUSE_W-1:0] pause_cnt;
    logic [2:0]         fld;      // window byte 0..4 or colour byte 0..2
    logic [DIGIT_W-1:0] dig_idx;
    coord_t             row, col;
    bcd_t               digits [NUM_DIGITS];
    color_t             fg_c [3];
    color_t             bg_c [3];
    coord_t             x_lo, x_hi, y_lo, y_hi;
    bcd_t               cur_digit;
    logic               lit, emit, px_last;
    byte_t              nxt_data;
    logic               nxt_user, nxt_last;

    function automatic byte_t win_byte(byte_t cmd, coord_t lo, coord_t hi, logic [2:0] idx);
        case (idx)
            3'd1:    return lo[15:8];
            3'd2:    return lo[7:0];
            3'd3:    return hi[15:8];
            3'd4:    return hi[7:0];
            default: return cmd;
        endcase
    endfunction

    assign x_lo      = coord_t'(ORIGIN_X + DIGIT_PITCH * dig_idx);
    assign x_hi      = x_lo + coord_t'(GLYPH_W - 1);
    assign y_lo      = coord_t'(ORIGIN_Y);
    assign y_hi      = coord_t'(ORIGIN_Y + GLYPH_H - 1);
    assign cur_digit = digits[dig_idx];
    assign px_last   = (fld == 3'd2) && (col == coord_t'(GLYPH_W - 1))
                       && (row == coord_t'(GLYPH_H - 1));

    glyph_gen u_glyph (
        .digit (cur_digit),
        .row   (row),
        .col   (col),
        .lit   (lit)
    );

    always_comb begin
        nxt_data = CMD_SWRESET;
        nxt_user = 1'b0;
        nxt_last = 1'b1;
        emit     = !wr.awfull;
        case (state)
            S_SWRESET: nxt_data = CMD_SWRESET;
            S_SLPOUT:  nxt_data = CMD_SLPOUT;
            S_INVON:   nxt_data = CMD_INVON;
            S_DISPON:  nxt_data = CMD_DISPON;
            S_CASET, S_RASET: begin
                nxt_data = (state == S_CASET) ? win_byte(CMD_CASET, x_lo, x_hi, fld)
                                              : win_byte(CMD_RASET, y_lo, y_hi, fld);
                nxt_user = (fld != 3'd0);
                nxt_last = (fld == 3'd4);
            end
            S_RAMWR: begin
                nxt_data = CMD_RAMWR;
                nxt_last = 1'b0;
            end
            S_PIXEL: begin
                nxt_data = lit ? fg_c[fld[1:0]] : bg_c[fld[1:0]];
                nxt_user = 1'b1;
                nxt_last = px_last;
            end
            default: emit = 1'b0;  // reset, pause, idle send nothing
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= S_RESET;
            pause_cnt <= '0;
            fld       <= '0;
            dig_idx   <= '0;
            row       <= '0;
            col       <= '0;
        end else begin
            case (state)
                S_RESET:   state <= S_SWRESET;
                S_SWRESET: if (!wr.awfull) state <= S_PAUSE;
                S_PAUSE: begin
                    if (pause_cnt == PAUSE_W'(PAUSE_CYCLES - 1)) begin
                        pause_cnt <= '0;
                        state     <= S_SLPOUT;
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end
                S_SLPOUT: if (!wr.awfull) state <= S_INVON;
                S_INVON:  if (!wr.awfull) state <= S_DISPON;
                S_DISPON: if (!wr.awfull) state <= S_IDLE;
                S_IDLE: begin
                    if (time_valid) begin
                        dig_idx <= '0;
                        fld     <= '0;
                        state   <= S_CASET;
                    end
                end
                S_CASET, S_RASET: begin
                    if (!wr.awfull) begin
                        if (fld == 3'd4) begin
                            fld   <= '0;
                            state <= (state == S_CASET) ? S_RASET : S_RAMWR;
                        end else begin
                            fld <= fld + 1'b1;
                        end
                    end
                end
                S_RAMWR: begin
                    if (!wr.awfull) begin
                        row   <= '0;
                        col   <= '0;
                        fld   <= '0;
                        state <= S_PIXEL;
                    end
                end
                S_PIXEL: begin
                    if (!wr.awfull) begin
                        if (fld != 3'd2) begin
                            fld <= fld + 1'b1;
                        end else begin
                            fld <= '0;
                            if (col != coord_t'(GLYPH_W - 1)) begin
                                col <= col + 1'b1;
                            end else begin
                                col <= '0;
                                if (row != coord_t'(GLYPH_H - 1)) begin
                                    row <= row + 1'b1;
                                end else if (dig_idx == DIGIT_W'(NUM_DIGITS - 1)) begin
                                    state <= S_IDLE;
                                end else begin
                                    row     <= '0;
                                    dig_idx <= dig_idx + 1'b1;
                                    state   <= S_CASET;
                                end
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // snapshot, so inputs may change while a frame is drawn
    always_ff @(posedge CLK) begin
        if (state == S_IDLE && time_valid) begin
            digits[0] <= hour_h;
            digits[1] <= hour_l;
            digits[2] <= min_h;
            digits[3] <= min_l;
            digits[4] <= sec_h;
            digits[5] <= sec_l;
            fg_c[0]   <= fg_r;
            fg_c[1]   <= fg_g;
            fg_c[2]   <= fg_b;
            bg_c[0]   <= bg_r;
            bg_c[1]   <= bg_g;
            bg_c[2]   <= bg_b;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            wr.wren <= 1'b0;
        else
            wr.wren <= emit;
    end

    always_ff @(posedge CLK) begin
        if (emit) begin
            wr.data <= nxt_data;
            wr.user <= nxt_user;
            wr.last <= nxt_last;
        end
    end

    // fifo margin relies on this one-cycle reaction to almost-full
    a_awfull_stall: assert property (@(posedge CLK) disable iff (RESET)
        $past(wr.awfull) |-> !wr.wren)
        else $error("write issued after almost-full");

endmodule

// ==== verilog/glyph_gen.sv ====
`timescale 1ns/1ps

module glyph_gen import st7789_pkg::*; (
    input  bcd_t   digit,
    input  coord_t row,
    input  coord_t col,
    output logic   lit
);

    logic [6:0] seg;  // a b c d e f g
    logic [6:0] hit;
    logic       left, right, upper, lower;

    always_comb begin
        case (digit)
            4'd1:    seg = 7'b0110000;
            4'd2:    seg = 7'b1101101;
            4'd3:    seg = 7'b1111001;
            4'd4:    seg = 7'b0110011;
            4'd5:    seg = 7'b1011011;
            4'd6:    seg = 7'b1011111;
            4'd7:    seg = 7'b1110000;
            4'd8:    seg = 7'b1111111;
            4'd9:    seg = 7'b1111011;
            default: seg = 7'b1111110;  // 0, also for non-bcd values
        endcase
    end

    assign left  = (col < STROKE);
    assign right = (col >= GLYPH_W - STROKE) && (col < GLYPH_W);
    assign upper = (row < GLYPH_MID + STROKE);
    assign lower = (row >= GLYPH_MID) && (row < GLYPH_H);

    // verticals overlap the horizontals at the corners
    assign hit[6] = (row < STROKE);
    assign hit[5] = right && upper;
    assign hit[4] = right && lower;
    assign hit[3] = (row >= GLYPH_H - STROKE) && (row < GLYPH_H);
    assign hit[2] = left && lower;
    assign hit[1] = left && upper;
    assign hit[0] = (row >= GLYPH_MID) && (row < GLYPH_MID + STROKE);

    assign lit = |(seg & hit);

endmodule

// ==== verilog/lcd_rd_if.sv ====
`timescale 1ns/1ps

// show-ahead read side, head entry valid while empty is low
interface lcd_rd_if import st7789_pkg::*; ();

    byte_t data;
    logic  user;
    logic  last;
    logic  rden;
    logic  empty;

    modport fifo (output data, output user, output last, output empty, input rden);

    modport consumer (input data, input user, input last, input empty, output rden);

endinterface

// ==== verilog/lcd_wr_if.sv ====
`timescale 1ns/1ps

interface lcd_wr_if import st7789_pkg::*; ();

    byte_t data;
    logic  user;
    logic  last;
    logic  wren;
    logic  awfull;

    modport producer (output data, output user, output last, output wren, input awfull);

    modport fifo (input data, input user, input last, input wren, output awfull);

endinterface

// ==== verilog/st7789_pkg.sv ====
package st7789_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  bcd_t;
    typedef logic [15:0] coord_t;
    typedef logic [7:0]  color_t;

    // panel commands
    localparam byte_t CMD_SWRESET = 8'h01;
    localparam byte_t CMD_SLPOUT  = 8'h11;
    localparam byte_t CMD_INVON   = 8'h21;
    localparam byte_t CMD_DISPON  = 8'h29;
    localparam byte_t CMD_CASET   = 8'h2A;
    localparam byte_t CMD_RASET   = 8'h2B;
    localparam byte_t CMD_RAMWR   = 8'h2C;

    // glyph geometry in pixels
    localparam int GLYPH_W     = 8;
    localparam int GLYPH_H     = 12;
    localparam int STROKE      = 2;
    localparam int GLYPH_GAP   = 4;
    localparam int GLYPH_MID   = (GLYPH_H - STROKE) / 2;  // first row of segment g
    localparam int DIGIT_PITCH = GLYPH_W + GLYPH_GAP;
    localparam int ORIGIN_X    = 10;
    localparam int ORIGIN_Y    = 20;

    localparam int NUM_DIGITS   = 6;
    localparam int DIGIT_W      = $clog2(NUM_DIGITS);
    localparam int PAUSE_CYCLES = 500;
    localparam int PAUSE_W      = $clog2(PAUSE_CYCLES);

    // byte fifo
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_AWFULL = 12;
    localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
    localparam int FIFO_W      = 10;  // last, user, data

endpackage
